// ==== md_wb.f ====
source/md_pkg.sv
source/wb_pkg.sv
source/md_wb_regs.sv
source/mul_operand_split.sv
source/mul_partial_lane.sv
source/mul_accumulate.sv
source/div_long.sv
source/md_wb_top.sv
testbench/md_wb_sva.sv
testbench/md_wb_tb.sv

// ==== Bender.yml ====
package:
  name: md_wb

sources:
  - source/md_pkg.sv
  - source/wb_pkg.sv
  - source/md_wb_regs.sv
  - source/mul_operand_split.sv
  - source/mul_partial_lane.sv
  - source/mul_accumulate.sv
  - source/div_long.sv
  - source/md_wb_top.sv
  - target: test
    files:
      - testbench/md_wb_sva.sv
      - testbench/md_wb_tb.sv

// ==== testbench/md_wb_tb.sv ====
//####################################################################
// drives the coprocessor over Wishbone with inputs on the falling edge
// one access at a time, stb drops one cycle after ack is seen
// expected values come from a 64-bit reference model
//####################################################################
`default_nettype none

module md_wb_tb import md_pkg::*, wb_pkg::*;;

  localparam int PERIOD    = 100;
  localparam int N_RAND    = 24;
  localparam int N_ZERO    = 4;
  localparam int BUS_LIMIT = 100;
  // reset reads, corners, random, overflow, divide by zero, back-pressure, readback
  localparam int N_OPS     = 1 + 16 * 8 + N_RAND * 8 + 2 + N_ZERO * 4 + 3 + 1;
  localparam int WATCHDOG  = (N_OPS * 60 + 10) * PERIOD;

  logic        clk = 1'b0;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [31:0] lfsr_q = 32'h2b51;
  logic [31:0] corners [4];
  int          checks;
  int          errors;
  int          wait_cycles;

  md_wb_top DUT (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  always #(PERIOD / 2) clk = ~clk;

  // fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // RISC-V M semantics, zero divisor gives all ones and the dividend
  function automatic logic [31:0] ref_result(input md_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    longint sa;
    longint sb;
    longint ua;
    longint ub;
    longint p;
    sa = longint'(signed'(a));
    sb = longint'(signed'(b));
    ua = longint'({32'h0, a});
    ub = longint'({32'h0, b});
    case (op)
      OP_MUL:    p = ua * ub;
      OP_MULH:   p = (sa * sb) >>> 32;
      OP_MULHSU: p = (sa * ub) >>> 32;
      OP_MULHU:  p = (ua * ub) >> 32;
      OP_DIV:    p = (b == 0) ? -1 : sa / sb;
      OP_DIVU:   p = (b == 0) ? -1 : ua / ub;
      OP_REM:    p = (b == 0) ? sa : sa % sb;
      default:   p = (b == 0) ? ua : ua % ub;
    endcase
    return p[31:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: actual %h expected %h", name, actual, expected);
    end
  endtask

  task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    wait_cycles = 0;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    while (!wb_rsp.ack && wait_cycles < BUS_LIMIT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!wb_rsp.ack) begin
      errors++;
      $display("bus hang: no ack within %0d cycles at word address %0d", BUS_LIMIT, adr);
    end
    rdat = wb_rsp.dat;
    // hold stb through the edge where the slave sees its own ack
    @(negedge clk);
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  task automatic run_op(input md_op_e op, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] rd;
    wb_write(REG_OP_A, a);
    wb_write(REG_OP_B, b);
    wb_write(REG_CMD, {29'h0, op});
    wb_read(REG_CMD, rd);
    check_value($sformatf("result %s a=%h b=%h", op.name(), a, b), rd, ref_result(op, a, b));
  endtask

  initial begin
    #(WATCHDOG);
    $display("watchdog: run did not finish within %0d time units", WATCHDOG);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] a;
    logic [31:0] b;
    wb_req  = '0;
    rst_n   = 1'b0;
    checks  = 0;
    errors  = 0;
    corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    wb_read(REG_STATUS, rd);
    check_value("status after reset", rd, 32'h0);
    wb_read(REG_CMD, rd);
    check_value("result after reset", rd, 32'h0);

    // corner pairs include the zero divisor and -2^31 / -1
    for (int k = 0; k < 8; k++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          run_op(md_op_e'(k), corners[i], corners[j]);
        end
      end
    end

    // narrower divisors give quotients with more set bits
    for (int k = 0; k < 8; k++) begin
      for (int n = 0; n < N_RAND; n++) begin
        a = rand_bits(32);
        b = rand_bits(32);
        if (k >= 4) begin
          b = b >> rand_bits(5);
        end
        run_op(md_op_e'(k), a, b);
      end
    end

    run_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_op(OP_REM, 32'h8000_0000, 32'hffff_ffff);

    for (int n = 0; n < N_ZERO; n++) begin
      a = rand_bits(32);
      for (int k = 4; k < 8; k++) begin
        run_op(md_op_e'(k), a, 32'h0);
      end
    end

    // second command arrives while the first divide still runs
    a = rand_bits(32);
    b = rand_bits(32) | 32'h1;
    wb_write(REG_OP_A, a);
    wb_write(REG_OP_B, b);
    wb_write(REG_CMD, {29'h0, OP_DIV});
    wb_read(REG_STATUS, rd);
    check_value("status busy bit", rd, 32'h1);
    wb_write(REG_CMD, {29'h0, OP_REM});
    check_value("cmd ack held while busy", 32'(wait_cycles > 20), 32'h1);
    wb_read(REG_CMD, rd);
    check_value("result after held cmd", rd, ref_result(OP_REM, a, b));

    a = rand_bits(32);
    b = rand_bits(32);
    wb_write(REG_OP_A, a);
    wb_write(REG_OP_B, b);
    wb_read(REG_OP_A, rd);
    check_value("operand a readback", rd, a);
    wb_read(REG_OP_B, rd);
    check_value("operand b readback", rd, b);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/md_wb_sva.sv ====
//####################################################################
// bus handshake and engine start checks, bound into md_wb_regs
// assumes the master holds stb until the cycle after ack
//####################################################################
`default_nettype none

module md_wb_sva import md_pkg::*, wb_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input wb_req_t  wb_req_i,
  input wb_rsp_t  wb_rsp_i,
  input mul_req_t mul_req_i,
  input div_req_t div_req_i,
  input logic     busy_i
);

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else $error("ack held longer than one cycle");

  ack_needs_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else $error("ack without an active strobe");

  // a command is only dispatched to an idle unit
  start_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mul_req_i.start || div_req_i.start) |-> !busy_i)
    else $error("engine start while busy");

  one_engine_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(mul_req_i.start && div_req_i.start))
    else $error("both engines started together");

endmodule

bind md_wb_regs md_wb_sva u_sva (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .wb_req_i  (wb_req_i),
  .wb_rsp_i  (wb_rsp_o),
  .mul_req_i (mul_req_o),
  .div_req_i (div_req_o),
  .busy_i    (busy_q)
);

`default_nettype wire

// ==== source/md_wb_top.sv ====
//####################################################################
// multiply/divide coprocessor behind a Wishbone classic slave
// multiply takes 3 cycles, divide 36, divide by zero 2
//####################################################################
`default_nettype none

module md_wb_top import md_pkg::*, wb_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  mul_req_t    mul_req;
  mul_halves_t mul_halves;
  md_rsp_t     mul_rsp;
  div_req_t    div_req;
  md_rsp_t     div_rsp;

  logic signed [2*HALF_W+1:0] lane_prod [4];
  logic lane_valid [4];
  logic lane_high [4];

  md_wb_regs u_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wb_req_i  (wb_req_i),
    .wb_rsp_o  (wb_rsp_o),
    .mul_req_o (mul_req),
    .div_req_o (div_req),
    .mul_rsp_i (mul_rsp),
    .div_rsp_i (div_rsp)
  );

  mul_operand_split u_split (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (mul_req),
    .halves_o (mul_halves)
  );

  for (genvar i = 0; i < 4; i++) begin : g_lane
    mul_partial_lane #(
      .LANE (i)
    ) u_lane (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .halves_i (mul_halves),
      .prod_o   (lane_prod[i]),
      .valid_o  (lane_valid[i]),
      .high_o   (lane_high[i])
    );
  end

  // all lanes carry identical control, lane 0 speaks for them
  mul_accumulate u_acc (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .prod_i  (lane_prod),
    .valid_i (lane_valid[0]),
    .high_i  (lane_high[0]),
    .rsp_o   (mul_rsp)
  );

  div_long #(
    .DIV_W (XLEN)
  ) u_div (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (div_req),
    .rsp_o  (div_rsp)
  );

endmodule

`default_nettype wire

// ==== source/div_long.sv ====
//####################################################################
// restoring divider, one quotient bit per cycle, start only in idle
// a zero divisor skips straight to finish with fixed results
// -2^31 / -1 gives -2^31 and remainder 0 without special casing
//####################################################################
`default_nettype none

module div_long import md_pkg::*; #(
  parameter int unsigned DIV_W = 32
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  div_req_t req_i,
  output md_rsp_t  rsp_o
);

  localparam int unsigned CNT_W = $clog2(DIV_W);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ABS_A,
    S_ABS_B,
    S_COMP,
    S_LAST,
    S_CHANGE_SIGN,
    S_FINISH
  } div_state_e;

  div_state_e state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [DIV_W-1:0] a_q, b_q, numer_q, denom_q, quot_q, rem_q;
  logic is_rem_q, sign_a_q, sign_b_q;

  logic [DIV_W:0] sub_a, sub_b;
  logic [DIV_W+1:0] diff;
  logic ge;
  logic [DIV_W-1:0] step_rem, step_quot, bit_mask;
  logic neg_result;

  // the one subtractor serves abs values, trial subtraction and sign change
  always_comb begin
    sub_a = '0;
    sub_b = '0;
    case (state_q)
      S_ABS_A: sub_b = {1'b0, a_q};
      S_ABS_B: sub_b = {1'b0, b_q};
      S_COMP, S_LAST: begin
        // partial remainder shifted left with the next numerator bit
        sub_a = {rem_q, numer_q[cnt_q]};
        sub_b = {1'b0, denom_q};
      end
      S_CHANGE_SIGN: sub_b = {1'b0, rem_q};
      default: ;
    endcase
  end

  assign diff       = {1'b0, sub_a} - {1'b0, sub_b};
  assign ge         = ~diff[DIV_W+1];
  assign step_rem   = ge ? diff[DIV_W-1:0] : sub_a[DIV_W-1:0];
  assign bit_mask   = {{(DIV_W-1){1'b0}}, 1'b1} << cnt_q;
  assign step_quot  = ge ? (quot_q | bit_mask) : quot_q;
  // remainder takes the dividend sign, quotient the xor of both
  assign neg_result = is_rem_q ? sign_a_q : (sign_a_q ^ sign_b_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= S_IDLE;
      cnt_q    <= '0;
      a_q      <= '0;
      b_q      <= '0;
      numer_q  <= '0;
      denom_q  <= '0;
      quot_q   <= '0;
      rem_q    <= '0;
      is_rem_q <= 1'b0;
      sign_a_q <= 1'b0;
      sign_b_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req_i.start) begin
            a_q      <= req_i.dividend;
            b_q      <= req_i.divisor;
            is_rem_q <= req_i.rem;
            sign_a_q <= req_i.is_signed & req_i.dividend[DIV_W-1];
            sign_b_q <= req_i.is_signed & req_i.divisor[DIV_W-1];
            if (req_i.divisor == '0) begin
              rem_q   <= req_i.rem ? req_i.dividend : '1;
              state_q <= S_FINISH;
            end else begin
              state_q <= S_ABS_A;
            end
          end
        end
        S_ABS_A: begin
          numer_q <= sign_a_q ? diff[DIV_W-1:0] : a_q;
          quot_q  <= '0;
          rem_q   <= '0;
          state_q <= S_ABS_B;
        end
        S_ABS_B: begin
          denom_q <= sign_b_q ? diff[DIV_W-1:0] : b_q;
          cnt_q   <= CNT_W'(DIV_W - 1);
          state_q <= S_COMP;
        end
        S_COMP: begin
          rem_q  <= step_rem;
          quot_q <= step_quot;
          cnt_q  <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1)) begin
            state_q <= S_LAST;
          end
        end
        S_LAST: begin
          // from here on rem_q holds the selected result
          rem_q   <= is_rem_q ? step_rem : step_quot;
          state_q <= S_CHANGE_SIGN;
        end
        S_CHANGE_SIGN: begin
          if (neg_result) begin
            rem_q <= diff[DIV_W-1:0];
          end
          state_q <= S_FINISH;
        end
        S_FINISH: state_q <= S_IDLE;
        default:  state_q <= S_IDLE;
      endcase
    end
  end

  assign rsp_o.done   = (state_q == S_FINISH);
  assign rsp_o.result = rem_q;

endmodule

`default_nettype wire

// ==== source/mul_accumulate.sv ====
//####################################################################
// last multiply stage, done follows valid by one cycle
// the 64-bit sum is exact modulo 2^64 for every sign mode
//####################################################################
`default_nettype none

module mul_accumulate import md_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic signed [2*HALF_W+1:0] prod_i [4],
  input  logic                       valid_i,
  input  logic                       high_i,
  output md_rsp_t                    rsp_o
);

  logic signed [2*XLEN-1:0] ext [4];
  logic signed [2*XLEN-1:0] sum;
  md_rsp_t rsp_q;

  always_comb begin
    // sign extension happens in the assignment
    for (int i = 0; i < 4; i++) begin
      ext[i] = prod_i[i];
    end
    sum = ext[0]
        + (ext[1] <<< HALF_W)
        + (ext[2] <<< HALF_W)
        + (ext[3] <<< (2 * HALF_W));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q <= '0;
    end else begin
      rsp_q.done <= valid_i;
      if (valid_i) begin
        rsp_q.result <= high_i ? sum[2*XLEN-1:XLEN] : sum[XLEN-1:0];
      end
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// ==== source/mul_partial_lane.sv ====
//####################################################################
// LANE 0..3 selects al*bl, al*bh, ah*bl, ah*bh
//####################################################################
`default_nettype none

module mul_partial_lane import md_pkg::*; #(
  parameter int unsigned LANE = 0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  mul_halves_t                halves_i,
  output logic signed [2*HALF_W+1:0] prod_o,
  output logic                       valid_o,
  output logic                       high_o
);

  localparam bit USE_A_HI = (LANE >= 2);
  localparam bit USE_B_HI = ((LANE % 2) == 1);

  logic signed [HALF_W:0] op_a, op_b;
  logic signed [2*HALF_W+1:0] prod_q;
  logic valid_q, high_q;

  assign op_a = USE_A_HI ? halves_i.a_hi : halves_i.a_lo;
  assign op_b = USE_B_HI ? halves_i.b_hi : halves_i.b_lo;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prod_q  <= '0;
      valid_q <= 1'b0;
      high_q  <= 1'b0;
    end else begin
      // 17x17 signed kernel
      prod_q  <= op_a * op_b;
      valid_q <= halves_i.valid;
      high_q  <= halves_i.high;
    end
  end

  assign prod_o  = prod_q;
  assign valid_o = valid_q;
  assign high_o  = high_q;

endmodule

`default_nettype wire

// ==== source/mul_operand_split.sv ====
//####################################################################
// first multiply stage, takes a new request every cycle
// sign flags only affect the high halves
//####################################################################
`default_nettype none

module mul_operand_split import md_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  mul_req_t    req_i,
  output mul_halves_t halves_o
);

  mul_halves_t halves_d, halves_q;
  logic ext_a, ext_b;

  assign ext_a = req_i.sign_a & req_i.a[XLEN-1];
  assign ext_b = req_i.sign_b & req_i.b[XLEN-1];

  always_comb begin
    halves_d       = halves_q;
    halves_d.valid = req_i.start;
    if (req_i.start) begin
      halves_d.high = req_i.high;
      halves_d.a_lo = {1'b0, req_i.a[HALF_W-1:0]};
      halves_d.a_hi = {ext_a, req_i.a[XLEN-1:HALF_W]};
      halves_d.b_lo = {1'b0, req_i.b[HALF_W-1:0]};
      halves_d.b_hi = {ext_b, req_i.b[XLEN-1:HALF_W]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halves_q <= '0;
    end else begin
      halves_q <= halves_d;
    end
  end

  assign halves_o = halves_q;

endmodule

`default_nettype wire

// ==== source/md_wb_regs.sv ====
//####################################################################
// one access at a time, ack is registered and lasts one cycle
// command writes and result reads are held off while busy
// operand registers stay writable during a running operation
//####################################################################
`default_nettype none

module md_wb_regs import md_pkg::*, wb_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  wb_req_t  wb_req_i,
  output wb_rsp_t  wb_rsp_o,
  output mul_req_t mul_req_o,
  output div_req_t div_req_o,
  input  md_rsp_t  mul_rsp_i,
  input  md_rsp_t  div_rsp_i
);

  logic [XLEN-1:0] op_a_q, op_b_q, result_q;
  logic [WB_DW-1:0] rdata_q, rdata_d;
  logic busy_q, ack_q;
  logic access, is_cmd, accept, cmd_start;
  md_op_e cmd_op;

  // a new access only starts once the previous ack has been seen
  assign access    = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign is_cmd    = (wb_req_i.adr == REG_CMD);
  assign accept    = access & ~(is_cmd & busy_q);
  assign cmd_start = accept & wb_req_i.we & is_cmd;
  assign cmd_op    = md_op_e'(wb_req_i.dat[2:0]);

  // translate the operator into engine request flags
  always_comb begin
    mul_req_o          = '0;
    div_req_o          = '0;
    mul_req_o.a        = op_a_q;
    mul_req_o.b        = op_b_q;
    div_req_o.dividend = op_a_q;
    div_req_o.divisor  = op_b_q;
    case (cmd_op)
      OP_MUL: begin
        mul_req_o.start = cmd_start;
      end
      OP_MULH: begin
        mul_req_o.start  = cmd_start;
        mul_req_o.high   = 1'b1;
        mul_req_o.sign_a = 1'b1;
        mul_req_o.sign_b = 1'b1;
      end
      OP_MULHSU: begin
        mul_req_o.start  = cmd_start;
        mul_req_o.high   = 1'b1;
        mul_req_o.sign_a = 1'b1;
      end
      OP_MULHU: begin
        mul_req_o.start = cmd_start;
        mul_req_o.high  = 1'b1;
      end
      OP_DIV: begin
        div_req_o.start     = cmd_start;
        div_req_o.is_signed = 1'b1;
      end
      OP_DIVU: begin
        div_req_o.start = cmd_start;
      end
      OP_REM: begin
        div_req_o.start     = cmd_start;
        div_req_o.rem       = 1'b1;
        div_req_o.is_signed = 1'b1;
      end
      default: begin
        div_req_o.start = cmd_start;
        div_req_o.rem   = 1'b1;
      end
    endcase
  end

  always_comb begin
    case (wb_req_i.adr)
      REG_OP_A: rdata_d = op_a_q;
      REG_OP_B: rdata_d = op_b_q;
      REG_CMD:  rdata_d = result_q;
      default:  rdata_d = {{(WB_DW-1){1'b0}}, busy_q};
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_a_q   <= '0;
      op_b_q   <= '0;
      result_q <= '0;
      rdata_q  <= '0;
      busy_q   <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= accept;
      if (accept && wb_req_i.we) begin
        if (wb_req_i.adr == REG_OP_A) begin
          op_a_q <= wb_req_i.dat;
        end
        if (wb_req_i.adr == REG_OP_B) begin
          op_b_q <= wb_req_i.dat;
        end
      end
      if (accept && !wb_req_i.we) begin
        rdata_q <= rdata_d;
      end
      // only one engine runs at a time, so the done pulses never collide
      if (cmd_start) begin
        busy_q <= 1'b1;
      end else if (mul_rsp_i.done || div_rsp_i.done) begin
        busy_q <= 1'b0;
      end
      if (mul_rsp_i.done) begin
        result_q <= mul_rsp_i.result;
      end else if (div_rsp_i.done) begin
        result_q <= div_rsp_i.result;
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

// ==== source/wb_pkg.sv ====
//####################################################################
// Wishbone classic slave types and the four-word register map
//####################################################################
`default_nettype none

package wb_pkg;

  localparam int unsigned WB_AW = 2;
  localparam int unsigned WB_DW = 32;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

  // word addresses
  localparam logic [WB_AW-1:0] REG_OP_A   = 2'd0;
  localparam logic [WB_AW-1:0] REG_OP_B   = 2'd1;
  localparam logic [WB_AW-1:0] REG_CMD    = 2'd2;
  localparam logic [WB_AW-1:0] REG_STATUS = 2'd3;

endpackage

`default_nettype wire

// ==== source/md_pkg.sv ====
//####################################################################
// arithmetic types shared by the multiply pipeline and the divider
// operator encoding follows the RISC-V M extension funct3 order
//####################################################################
`default_nettype none

package md_pkg;

  localparam int unsigned XLEN   = 32;
  localparam int unsigned HALF_W = 16;

  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } md_op_e;

  typedef struct packed {
    logic            start;
    logic            high;
    logic            sign_a;
    logic            sign_b;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } mul_req_t;

  // low halves carry a zero sign bit, high halves the operand sign
  typedef struct packed {
    logic                   valid;
    logic                   high;
    logic signed [HALF_W:0] a_lo;
    logic signed [HALF_W:0] a_hi;
    logic signed [HALF_W:0] b_lo;
    logic signed [HALF_W:0] b_hi;
  } mul_halves_t;

  typedef struct packed {
    logic            start;
    logic            rem;
    logic            is_signed;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
  } div_req_t;

  typedef struct packed {
    logic            done;
    logic [XLEN-1:0] result;
  } md_rsp_t;

endpackage

`default_nettype wire
